//--- taskwait_golden.txt
# creator  child_count_N  expected_ack_data
# lines 1-4 in order, 5-7 finishes first, the rest concurrent with distinct creators
3 5 5
7 1 1
12 0 0
3 2 2
9 4 4
0 3 3
15 1 1
1 6 6
2 0 0
4 3 3
5 8 8
6 2 2
8 5 5
10 1 1
11 7 7
13 4 4
14 2 2
12 3 3

//--- sim.f
taskwait_pkg.sv
stream_arbiter.sv
tw_clear_counter.sv
tw_info_mem.sv
taskwait_fsm.sv
taskwait_manager.sv
tb_clock.sv
taskwait_assertions.sv
taskwait_manager_tb.sv

//--- run.sh
#!/bin/sh
# Builds the taskwait manager testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module taskwait_manager_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtaskwait_manager_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

//--- taskwait_manager_tb.sv
// Testbench for the taskwait manager, stimulus and expected acks from taskwait_golden.txt.
// Runs in-order, early-finish and concurrent rounds under random ack back-pressure.
module taskwait_manager_tb;
    import taskwait_pkg::*;

    localparam int MAX_ACCS     = 16;
    localparam int ACC_BITS     = $clog2(MAX_ACCS);
    localparam int MAX_LINES    = 64;
    localparam int SEQ_LINES    = 4;
    localparam int EARLY_LINES  = 3;
    localparam int RESET_CYCLES = 8;

    logic                aclk;
    logic                reset;
    logic                taskwait_in_tvalid;
    logic                taskwait_in_tready;
    logic [ACC_BITS-1:0] taskwait_in_tid;
    logic [TDATA_W-1:0]  taskwait_in_tdata;
    logic                finish_in_tvalid;
    logic                finish_in_tready;
    logic [TDATA_W-1:0]  finish_in_tdata;
    logic                taskwait_out_tvalid;
    logic                taskwait_out_tready;
    logic [ACC_BITS-1:0] taskwait_out_tdest;
    logic [TDATA_W-1:0]  taskwait_out_tdata;

    int   line_acc [MAX_LINES];
    int   line_n   [MAX_LINES];
    int   line_exp [MAX_LINES];
    int   num_lines;
    logic loaded;

    // Current round of each creator
    logic round_open  [MAX_ACCS];
    logic tw_done     [MAX_ACCS];
    int   fin_done    [MAX_ACCS];
    int   round_n     [MAX_ACCS];
    int   round_exp   [MAX_ACCS];
    int   acks_seen   [MAX_ACCS];
    int   acks_golden [MAX_ACCS];

    int    value_errors;
    int    other_errors;
    string test_name;

    tb_clock #(.PERIOD(20)) clock_i (.clk(aclk));

    taskwait_manager #(.MAX_ACCS(MAX_ACCS)) dut_i (
        .aclk                (aclk),
        .reset               (reset),
        .taskwait_in_tvalid  (taskwait_in_tvalid),
        .taskwait_in_tready  (taskwait_in_tready),
        .taskwait_in_tid     (taskwait_in_tid),
        .taskwait_in_tdata   (taskwait_in_tdata),
        .finish_in_tvalid    (finish_in_tvalid),
        .finish_in_tready    (finish_in_tready),
        .finish_in_tdata     (finish_in_tdata),
        .taskwait_out_tvalid (taskwait_out_tvalid),
        .taskwait_out_tready (taskwait_out_tready),
        .taskwait_out_tdest  (taskwait_out_tdest),
        .taskwait_out_tdata  (taskwait_out_tdata)
    );

    bind taskwait_manager taskwait_assertions #(.MAX_ACCS(MAX_ACCS)) assertions_i (
        .aclk                (aclk),
        .reset               (reset),
        .clear_done          (clear_done),
        .taskwait_in_tvalid  (taskwait_in_tvalid),
        .taskwait_in_tready  (taskwait_in_tready),
        .finish_in_tvalid    (finish_in_tvalid),
        .finish_in_tready    (finish_in_tready),
        .taskwait_out_tvalid (taskwait_out_tvalid),
        .taskwait_out_tready (taskwait_out_tready),
        .taskwait_out_tdest  (taskwait_out_tdest),
        .taskwait_out_tdata  (taskwait_out_tdata)
    );

    task automatic load_golden();
        int    fd;
        int    acc;
        int    n;
        int    exp_data;
        string text;
        num_lines = 0;
        fd = $fopen("taskwait_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open taskwait_golden.txt");
            return;
        end
        // Comment and blank lines do not scan as three numbers
        while ($fgets(text, fd) != 0) begin
            if ($sscanf(text, "%d %d %d", acc, n, exp_data) == 3) begin
                if (acc < 0 || acc >= MAX_ACCS || num_lines >= MAX_LINES) begin
                    other_errors++;
                    $display("Golden line with creator %0d cannot be used", acc);
                end else begin
                    line_acc[num_lines] = acc;
                    line_n[num_lines]   = n;
                    line_exp[num_lines] = exp_data;
                    acks_golden[acc]++;
                    num_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int max_cycles);
        repeat ($urandom_range(0, max_cycles)) @(posedge aclk);
    endtask

    task automatic send_taskwait(input int acc, input int n);
        @(posedge aclk);
        taskwait_in_tvalid <= 1'b1;
        taskwait_in_tid    <= ACC_BITS'(acc);
        taskwait_in_tdata  <= TDATA_W'(n);
        @(negedge aclk);
        while (!taskwait_in_tready) @(negedge aclk);
        @(posedge aclk);
        taskwait_in_tvalid <= 1'b0;
        tw_done[acc] = 1'b1;
    endtask

    task automatic send_finish(input int acc);
        @(posedge aclk);
        finish_in_tvalid <= 1'b1;
        finish_in_tdata  <= TDATA_W'(acc);
        @(negedge aclk);
        while (!finish_in_tready) @(negedge aclk);
        @(posedge aclk);
        finish_in_tvalid <= 1'b0;
        fin_done[acc]++;
    endtask

    task automatic open_round(input int j);
        int acc;
        acc = line_acc[j];
        if (round_open[acc]) begin
            other_errors++;
            $display("Golden line %0d reuses creator %0d while its taskwait is open", j, acc);
        end
        round_open[acc] = 1'b1;
        tw_done[acc]    = 1'b0;
        fin_done[acc]   = 0;
        round_n[acc]    = line_n[j];
        round_exp[acc]  = line_exp[j];
    endtask

    task automatic wait_ack(input int acc);
        while (round_open[acc]) @(posedge aclk);
    endtask

    task automatic record_ack(input int acc, input logic [TDATA_W-1:0] data);
        acks_seen[acc]++;
        if (!round_open[acc]) begin
            other_errors++;
            $display("Ack at %0t went to creator %0d, which has no open taskwait", $time, acc);
            return;
        end
        if (!tw_done[acc] || fin_done[acc] != round_n[acc]) begin
            other_errors++;
            $display("Ack at %0t reached creator %0d before all its children finished",
                     $time, acc);
        end
        if (data != TDATA_W'(round_exp[acc])) begin
            value_errors++;
            $display("ERROR %s: creator %0d ack data expected %0d actual %0d",
                     test_name, acc, round_exp[acc], data);
        end
        round_open[acc] = 1'b0;
    endtask

    task automatic check_startup();
        repeat (MAX_ACCS) begin
            @(negedge aclk);
            if (taskwait_in_tready || finish_in_tready) begin
                other_errors++;
                $display("Input tready went high at %0t during the table sweep", $time);
            end
            if (taskwait_out_tvalid) begin
                other_errors++;
                $display("taskwait_out_tvalid went high at %0t during the table sweep", $time);
            end
        end
    endtask

    task automatic run_in_order(input int j);
        open_round(j);
        idle_cycles(3);
        send_taskwait(line_acc[j], line_n[j]);
        repeat (line_n[j]) begin
            idle_cycles(3);
            send_finish(line_acc[j]);
        end
        wait_ack(line_acc[j]);
    endtask

    task automatic run_early_finish(input int j);
        open_round(j);
        repeat (line_n[j]) begin
            idle_cycles(3);
            send_finish(line_acc[j]);
        end
        idle_cycles(3);
        send_taskwait(line_acc[j], line_n[j]);
        wait_ack(line_acc[j]);
    endtask

    task automatic run_concurrent(input int first);
        int fin_list[$];
        int pick;
        int tmp;
        for (int j = first; j < num_lines; j++) begin
            open_round(j);
            repeat (line_n[j]) fin_list.push_back(line_acc[j]);
        end
        // Shuffled so finishes land before and after their taskwait
        for (int i = fin_list.size() - 1; i > 0; i--) begin
            pick = $urandom_range(0, i);
            tmp = fin_list[i];
            fin_list[i] = fin_list[pick];
            fin_list[pick] = tmp;
        end
        fork
            begin
                for (int j = first; j < num_lines; j++) begin
                    idle_cycles(4);
                    send_taskwait(line_acc[j], line_n[j]);
                end
            end
            begin
                foreach (fin_list[i]) begin
                    idle_cycles(2);
                    send_finish(fin_list[i]);
                end
            end
        join
        for (int j = first; j < num_lines; j++) begin
            wait_ack(line_acc[j]);
        end
    endtask

    task automatic check_ack_counts();
        test_name = "ack_count";
        for (int acc = 0; acc < MAX_ACCS; acc++) begin
            if (acks_seen[acc] != acks_golden[acc]) begin
                value_errors++;
                $display("ERROR %s: creator %0d acks expected %0d actual %0d",
                         test_name, acc, acks_golden[acc], acks_seen[acc]);
            end
        end
    endtask

    initial begin : ack_monitor
        taskwait_out_tready <= 1'b0;
        forever begin
            @(negedge aclk);
            if (!reset && taskwait_out_tvalid && taskwait_out_tready) begin
                record_ack(int'(taskwait_out_tdest), taskwait_out_tdata);
            end
            @(posedge aclk);
            taskwait_out_tready <= ($urandom_range(0, 3) != 0);
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = num_lines * 200 + MAX_ACCS + RESET_CYCLES;
        repeat (limit) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut_i.assertions_i.fail_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h820b));
        reset              <= 1'b1;
        taskwait_in_tvalid <= 1'b0;
        taskwait_in_tid    <= '0;
        taskwait_in_tdata  <= '0;
        finish_in_tvalid   <= 1'b0;
        finish_in_tdata    <= '0;
        value_errors = 0;
        other_errors = 0;
        loaded       = 1'b0;
        test_name    = "startup";
        for (int acc = 0; acc < MAX_ACCS; acc++) begin
            round_open[acc]  = 1'b0;
            tw_done[acc]     = 1'b0;
            fin_done[acc]    = 0;
            acks_seen[acc]   = 0;
            acks_golden[acc] = 0;
        end
        load_golden();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;

        if (num_lines <= SEQ_LINES + EARLY_LINES) begin
            other_errors++;
            $display("Golden file holds only %0d usable lines", num_lines);
        end else begin
            // First taskwait waits at the input during the table sweep
            test_name = "in_order";
            fork
                run_in_order(0);
                check_startup();
            join
            for (int j = 1; j < SEQ_LINES; j++) begin
                run_in_order(j);
            end
            test_name = "early_finish";
            for (int j = SEQ_LINES; j < SEQ_LINES + EARLY_LINES; j++) begin
                run_early_finish(j);
            end
            test_name = "concurrent";
            run_concurrent(SEQ_LINES + EARLY_LINES);
        end

        // Late or duplicate acks would show up here
        repeat (20) @(posedge aclk);
        check_ack_counts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut_i.assertions_i.fail_count);
        if (value_errors == 0 && other_errors == 0
                && dut_i.assertions_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- taskwait_assertions.sv
// Concurrent handshake and reset checks for the taskwait manager.
// Bound into taskwait_manager by the testbench top.
module taskwait_assertions #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input logic                             aclk,
    input logic                             reset,
    input logic                             clear_done,
    input logic                             taskwait_in_tvalid,
    input logic                             taskwait_in_tready,
    input logic                             finish_in_tvalid,
    input logic                             finish_in_tready,
    input logic                             taskwait_out_tvalid,
    input logic                             taskwait_out_tready,
    input logic [ACC_BITS-1:0]              taskwait_out_tdest,
    input logic [taskwait_pkg::TDATA_W-1:0] taskwait_out_tdata
);

    logic accepted;
    int   fail_count = 0;

    assign accepted = (taskwait_in_tvalid && taskwait_in_tready)
                   || (finish_in_tvalid && finish_in_tready);

    ready_after_sweep: assert property (@(posedge aclk) disable iff (reset)
        !clear_done |-> !taskwait_in_tready && !finish_in_tready)
        else begin
            fail_count++;
            $error("input tready high before the table sweep finished");
        end

    out_held: assert property (@(posedge aclk) disable iff (reset)
        taskwait_out_tvalid && !taskwait_out_tready |=> taskwait_out_tvalid
            && $stable(taskwait_out_tdest) && $stable(taskwait_out_tdata))
        else begin
            fail_count++;
            $error("taskwait_out changed before its transfer");
        end

    out_idle_after_reset: assert property (@(posedge aclk)
        reset |=> !taskwait_out_tvalid)
        else begin
            fail_count++;
            $error("taskwait_out_tvalid high after reset");
        end

    // Ack rises two edges after the accepting edge
    ack_needs_message: assert property (@(posedge aclk) disable iff (reset)
        $rose(taskwait_out_tvalid) |-> $past(accepted, 3))
        else begin
            fail_count++;
            $error("ack raised without an accepted message");
        end

endmodule

//--- tb_clock.sv
// Free-running testbench clock
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- taskwait_manager.sv
// Taskwait manager top level, joins the stream merge, table sweep, table and controller.
// Accelerators send taskwaits and finishes, one ack per creator returns on taskwait_out.
module taskwait_manager #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               taskwait_in_tvalid,
    output logic                               taskwait_in_tready,
    input  logic [ACC_BITS-1:0]                taskwait_in_tid,
    input  logic [taskwait_pkg::TDATA_W-1:0]   taskwait_in_tdata,
    input  logic                               finish_in_tvalid,
    output logic                               finish_in_tready,
    input  logic [taskwait_pkg::TDATA_W-1:0]   finish_in_tdata,
    output logic                               taskwait_out_tvalid,
    input  logic                               taskwait_out_tready,
    output logic [ACC_BITS-1:0]                taskwait_out_tdest,
    output logic [taskwait_pkg::TDATA_W-1:0]   taskwait_out_tdata
);
    import taskwait_pkg::*;

    logic                msg_valid;
    logic                msg_ready;
    tw_kind_e            msg_kind;
    logic [ACC_BITS-1:0] msg_acc;
    logic [COUNT_W-1:0]  msg_count;

    logic [ACC_BITS-1:0] clear_addr;
    logic                clear_done;

    logic [ACC_BITS-1:0] rd_addr;
    tw_entry_t           rd_data;
    logic                wr_en;
    logic [ACC_BITS-1:0] wr_addr;
    tw_entry_t           wr_data;

    stream_arbiter #(.MAX_ACCS(MAX_ACCS)) arbiter_i (
        .aclk      (aclk),
        .reset     (reset),
        .tw_valid  (taskwait_in_tvalid),
        .tw_ready  (taskwait_in_tready),
        .tw_acc    (taskwait_in_tid),
        .tw_data   (taskwait_in_tdata),
        .fin_valid (finish_in_tvalid),
        .fin_ready (finish_in_tready),
        .fin_data  (finish_in_tdata),
        .msg_valid (msg_valid),
        .msg_ready (msg_ready),
        .msg_kind  (msg_kind),
        .msg_acc   (msg_acc),
        .msg_count (msg_count)
    );

    tw_clear_counter #(.MAX_ACCS(MAX_ACCS)) clear_i (
        .aclk       (aclk),
        .reset      (reset),
        .clear_addr (clear_addr),
        .clear_done (clear_done)
    );

    tw_info_mem #(.MAX_ACCS(MAX_ACCS)) mem_i (
        .aclk    (aclk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    taskwait_fsm #(.MAX_ACCS(MAX_ACCS)) fsm_i (
        .aclk                (aclk),
        .reset               (reset),
        .clear_addr          (clear_addr),
        .clear_done          (clear_done),
        .msg_valid           (msg_valid),
        .msg_ready           (msg_ready),
        .msg_kind            (msg_kind),
        .msg_acc             (msg_acc),
        .msg_count           (msg_count),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .taskwait_out_tvalid (taskwait_out_tvalid),
        .taskwait_out_tready (taskwait_out_tready),
        .taskwait_out_tdest  (taskwait_out_tdest),
        .taskwait_out_tdata  (taskwait_out_tdata)
    );

endmodule

//--- taskwait_fsm.sv
// Read-modify-write controller for the creator table.
// Clears the table after reset, then applies one message at a time and raises acks.
module taskwait_fsm #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic [ACC_BITS-1:0]                clear_addr,
    input  logic                               clear_done,
    input  logic                               msg_valid,
    output logic                               msg_ready,
    input  taskwait_pkg::tw_kind_e             msg_kind,
    input  logic [ACC_BITS-1:0]                msg_acc,
    input  logic [taskwait_pkg::COUNT_W-1:0]   msg_count,
    output logic [ACC_BITS-1:0]                rd_addr,
    input  taskwait_pkg::tw_entry_t            rd_data,
    output logic                               wr_en,
    output logic [ACC_BITS-1:0]                wr_addr,
    output taskwait_pkg::tw_entry_t            wr_data,
    output logic                               taskwait_out_tvalid,
    input  logic                               taskwait_out_tready,
    output logic [ACC_BITS-1:0]                taskwait_out_tdest,
    output logic [taskwait_pkg::TDATA_W-1:0]   taskwait_out_tdata
);
    import taskwait_pkg::*;

    tw_state_e           state;
    tw_state_e           state_next;

    // Latched message
    tw_kind_e            kind_q;
    logic [ACC_BITS-1:0] acc_q;
    logic [COUNT_W-1:0]  count_q;

    tw_entry_t           upd;
    tw_entry_t           upd_q;
    logic                ack_due;

    assign msg_ready = (state == IDLE);

    // Table output is valid in READ, address stays on the latched creator
    assign rd_addr = (state == IDLE) ? msg_acc : acc_q;

    always_comb begin
        upd = rd_data;
        if (kind_q == KIND_TASKWAIT) begin
            upd.pending   = rd_data.pending + $signed(count_q);
            upd.waiting   = 1'b1;
            upd.requested = count_q;
        end else begin
            upd.pending = rd_data.pending - $signed(count_q);
        end
    end

    assign ack_due = upd_q.waiting && (upd_q.pending == '0);

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = acc_q;
        wr_data = upd_q;
        if (state == CLEAR) begin
            wr_en   = !clear_done;
            wr_addr = clear_addr;
            wr_data = '0;
        end else if (state == UPDATE) begin
            wr_en = 1'b1;
            // Entry goes back to zero once its ack is sent
            if (ack_due) begin
                wr_data = '0;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CLEAR:  if (clear_done) state_next = IDLE;
            IDLE:   if (msg_valid) state_next = READ;
            READ:   state_next = UPDATE;
            UPDATE: state_next = ack_due ? ACK : IDLE;
            ACK:    if (taskwait_out_tready) state_next = IDLE;
            default: state_next = CLEAR;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= CLEAR;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == IDLE && msg_valid) begin
            kind_q  <= msg_kind;
            acc_q   <= msg_acc;
            count_q <= msg_count;
        end
        if (state == READ) begin
            upd_q <= upd;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            taskwait_out_tvalid <= 1'b0;
        end else if (state == UPDATE && ack_due) begin
            taskwait_out_tvalid <= 1'b1;
        end else if (taskwait_out_tready) begin
            taskwait_out_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == UPDATE && ack_due) begin
            taskwait_out_tdest <= acc_q;
            taskwait_out_tdata <= {{(TDATA_W - COUNT_W){1'b0}}, upd_q.requested};
        end
    end

endmodule

//--- tw_info_mem.sv
// Per-creator taskwait table, one registered read port and one write port.
module tw_info_mem #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input  logic                    aclk,
    input  logic [ACC_BITS-1:0]     rd_addr,
    output taskwait_pkg::tw_entry_t rd_data,
    input  logic                    wr_en,
    input  logic [ACC_BITS-1:0]     wr_addr,
    input  taskwait_pkg::tw_entry_t wr_data
);
    import taskwait_pkg::*;

    tw_entry_t mem [MAX_ACCS];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- tw_clear_counter.sv
// Address sweep that zeroes the creator table once after reset.
module tw_clear_counter #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input  logic                aclk,
    input  logic                reset,
    output logic [ACC_BITS-1:0] clear_addr,
    output logic                clear_done
);

    always_ff @(posedge aclk) begin
        if (reset) begin
            clear_addr <= '0;
            clear_done <= 1'b0;
        end else if (!clear_done) begin
            if (clear_addr == ACC_BITS'(MAX_ACCS - 1)) begin
                clear_done <= 1'b1;
            end else begin
                clear_addr <= clear_addr + 1'b1;
            end
        end
    end

endmodule

//--- stream_arbiter.sv
// Round-robin merge of the taskwait and finish streams into one message stream.
// A granted source keeps the grant until its handshake completes.
module stream_arbiter #(
    parameter int MAX_ACCS = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS)
) (
    input  logic                               aclk,
    input  logic                               reset,
    input  logic                               tw_valid,
    output logic                               tw_ready,
    input  logic [ACC_BITS-1:0]                tw_acc,
    input  logic [taskwait_pkg::TDATA_W-1:0]   tw_data,
    input  logic                               fin_valid,
    output logic                               fin_ready,
    input  logic [taskwait_pkg::TDATA_W-1:0]   fin_data,
    output logic                               msg_valid,
    input  logic                               msg_ready,
    output taskwait_pkg::tw_kind_e             msg_kind,
    output logic [ACC_BITS-1:0]                msg_acc,
    output logic [taskwait_pkg::COUNT_W-1:0]   msg_count
);
    import taskwait_pkg::*;

    // Selected source, 1 means finish
    logic sel;
    logic sel_q;
    logic hold_q;
    logic last_fin_q;

    always_comb begin
        if (hold_q) begin
            sel = sel_q;
        end else if (tw_valid && fin_valid) begin
            sel = ~last_fin_q;
        end else begin
            sel = fin_valid;
        end
    end

    assign msg_valid = sel ? fin_valid : tw_valid;
    assign tw_ready  = msg_ready && !sel;
    assign fin_ready = msg_ready && sel;

    assign msg_kind  = sel ? KIND_FINISH : KIND_TASKWAIT;
    assign msg_acc   = sel ? fin_data[ACC_BITS-1:0] : tw_acc;
    // A finish always retires one child
    assign msg_count = sel ? COUNT_W'(1) : tw_data[COUNT_W-1:0];

    always_ff @(posedge aclk) begin
        if (reset) begin
            hold_q     <= 1'b0;
            sel_q      <= 1'b0;
            last_fin_q <= 1'b0;
        end else if (msg_valid && msg_ready) begin
            hold_q     <= 1'b0;
            last_fin_q <= sel;
        end else if (msg_valid) begin
            hold_q <= 1'b1;
            sel_q  <= sel;
        end
    end

endmodule

//--- taskwait_pkg.sv
// Shared widths, message kinds and table types for the taskwait manager.
// Imported by the arbiter, the table, the controller and the top level.
package taskwait_pkg;

    localparam int TDATA_W = 64;
    localparam int COUNT_W = 32;

    // Kind of a message on the merged stream
    typedef enum logic [0:0] {
        KIND_TASKWAIT = 1'b0,
        KIND_FINISH   = 1'b1
    } tw_kind_e;

    // One record per creator, 65 bits
    typedef struct packed {
        logic                      waiting;
        logic signed [COUNT_W-1:0] pending;
        logic [COUNT_W-1:0]        requested;
    } tw_entry_t;

    typedef enum logic [2:0] {
        CLEAR  = 3'd0,
        IDLE   = 3'd1,
        READ   = 3'd2,
        UPDATE = 3'd3,
        ACK    = 3'd4
    } tw_state_e;

endpackage
